// File: hdl/core_pkg.sv
package core_pkg;

    // Data and address width
    localparam int xlen = 32;

    // Major opcodes
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_system = 7'b1110011;

    // funct3 values
    localparam logic [2:0] f3_add = 3'b000;
    localparam logic [2:0] f3_sll = 3'b001;
    localparam logic [2:0] f3_slt = 3'b010;
    localparam logic [2:0] f3_xor = 3'b100;
    localparam logic [2:0] f3_srl = 3'b101;
    localparam logic [2:0] f3_or  = 3'b110;
    localparam logic [2:0] f3_and = 3'b111;

    // funct7 for SUB
    localparam logic [6:0] f7_alt = 7'b0100000;

    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_and    = 4'd2,
        alu_or     = 4'd3,
        alu_xor    = 4'd4,
        alu_slt    = 4'd5,
        alu_sll    = 4'd6,
        alu_srl    = 4'd7,
        alu_pass_b = 4'd8
    } alu_op_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fields_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fields_t;

    // Same word, two layouts
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } instr_u;

endpackage

// File: hdl/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit import core_pkg::*; (
    input  logic            clk,
    input  logic            rstn,
    input  logic [xlen-1:0] fetch_data,
    input  logic            stop,
    output logic [xlen-1:0] fetch_addr,
    output logic            id_valid,
    output logic [xlen-1:0] id_pc,
    output logic [xlen-1:0] id_instr
);

    logic [xlen-1:0] pc;
    logic            halt_q;

    assign fetch_addr = pc;

    // Program counter, frozen once decode sees a halting word
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pc       <= '0;
            halt_q   <= 1'b0;
            id_valid <= 1'b0;
        end else begin
            if (stop) begin
                halt_q <= 1'b1;
            end
            if (!(stop || halt_q)) begin
                pc <= pc + 32'd4;
            end
            id_valid <= !(stop || halt_q);
        end
    end

    always_ff @(posedge clk) begin
        id_pc    <= pc;
        id_instr <= fetch_data;
    end

endmodule

// File: hdl/reg_file.sv
`timescale 1ns/1ps

module reg_file import core_pkg::*; (
    input  logic            clk,
    input  logic            rstn,
    input  logic [4:0]      rs1_addr,
    input  logic [4:0]      rs2_addr,
    output logic [xlen-1:0] rs1_data,
    output logic [xlen-1:0] rs2_data,
    input  logic            rf_wen,
    input  logic [4:0]      rf_waddr,
    input  logic [xlen-1:0] rf_wdata
);

    // x0 is not stored
    logic [xlen-1:0] regs [1:31];

    function automatic logic [xlen-1:0] read_port(input logic [4:0] addr);
        if (addr == 5'd0) begin
            return '0;
        end else if (rf_wen && rf_waddr == addr) begin
            return rf_wdata;
        end else begin
            return regs[addr];
        end
    endfunction

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rf_wen && rf_waddr != 5'd0) begin
            regs[rf_waddr] <= rf_wdata;
        end
    end

    // Same-cycle write passes straight through
    always_comb begin
        rs1_data = read_port(rs1_addr);
        rs2_data = read_port(rs2_addr);
    end

endmodule

// File: hdl/decode_unit.sv
`timescale 1ns/1ps

module decode_unit import core_pkg::*; (
    input  logic            clk,
    input  logic            rstn,
    input  logic            id_valid,
    input  logic [xlen-1:0] id_pc,
    input  logic [xlen-1:0] id_instr,
    output logic            stop,
    output logic [4:0]      rs1_addr,
    output logic [4:0]      rs2_addr,
    input  logic [xlen-1:0] rs1_data,
    input  logic [xlen-1:0] rs2_data,
    output logic            ex_valid,
    output logic [xlen-1:0] ex_pc,
    output alu_op_e         ex_alu_op,
    output logic [4:0]      ex_rs1,
    output logic [4:0]      ex_rs2,
    output logic [xlen-1:0] ex_rs1_data,
    output logic [xlen-1:0] ex_rs2_data,
    output logic [xlen-1:0] ex_imm,
    output logic            ex_use_imm,
    output logic [4:0]      ex_rd,
    output logic            ex_wen,
    output logic            ex_halt
);

    instr_u          instr;
    alu_op_e         alu_op;
    logic [xlen-1:0] imm;
    logic            use_imm;
    logic            legal;
    logic            is_halt;

    assign instr    = id_instr;
    assign is_halt  = (id_instr == '0) || (instr.r.opcode == opc_system);
    assign stop     = id_valid && is_halt;
    assign rs1_addr = instr.r.rs1;
    assign rs2_addr = instr.r.rs2;

////////////////////////////////////////
// Instruction decode

    always_comb begin
        alu_op  = alu_add;
        imm     = {{20{instr.i.imm12[11]}}, instr.i.imm12};
        use_imm = 1'b0;
        legal   = 1'b0;
        case (instr.r.opcode)
            opc_op: begin
                legal = (instr.r.funct7 == 7'd0);
                case (instr.r.funct3)
                    f3_add: begin
                        // funct7 picks ADD or SUB
                        alu_op = (instr.r.funct7 == f7_alt) ? alu_sub : alu_add;
                        legal  = (instr.r.funct7 == 7'd0) || (instr.r.funct7 == f7_alt);
                    end
                    f3_sll:  alu_op = alu_sll;
                    f3_slt:  alu_op = alu_slt;
                    f3_xor:  alu_op = alu_xor;
                    f3_srl:  alu_op = alu_srl;
                    f3_or:   alu_op = alu_or;
                    f3_and:  alu_op = alu_and;
                    default: legal = 1'b0;
                endcase
            end
            opc_op_imm: begin
                use_imm = 1'b1;
                legal   = 1'b1;
                case (instr.i.funct3)
                    f3_add:  alu_op = alu_add;
                    f3_slt:  alu_op = alu_slt;
                    f3_xor:  alu_op = alu_xor;
                    f3_or:   alu_op = alu_or;
                    f3_and:  alu_op = alu_and;
                    default: legal = 1'b0;
                endcase
            end
            opc_lui: begin
                // Upper 20 bits of the word, low 12 cleared
                alu_op  = alu_pass_b;
                imm     = {instr.i.imm12, instr.i.rs1, instr.i.funct3, 12'd0};
                use_imm = 1'b1;
                legal   = 1'b1;
            end
            default: begin
                legal = 1'b0;
            end
        endcase
    end

////////////////////////////////////////
// Decode to execute register

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ex_valid <= 1'b0;
            ex_wen   <= 1'b0;
            ex_halt  <= 1'b0;
        end else begin
            ex_valid <= id_valid;
            ex_wen   <= id_valid && legal && (instr.r.rd != 5'd0);
            ex_halt  <= stop;
        end
    end

    always_ff @(posedge clk) begin
        ex_pc       <= id_pc;
        ex_alu_op   <= alu_op;
        ex_rs1      <= rs1_addr;
        ex_rs2      <= rs2_addr;
        ex_rs1_data <= rs1_data;
        ex_rs2_data <= rs2_data;
        ex_imm      <= imm;
        ex_use_imm  <= use_imm;
        ex_rd       <= instr.r.rd;
    end

endmodule

// File: hdl/execute_unit.sv
`timescale 1ns/1ps

module execute_unit import core_pkg::*; (
    input  logic            clk,
    input  logic            rstn,
    input  logic            ex_valid,
    input  logic [xlen-1:0] ex_pc,
    input  alu_op_e         ex_alu_op,
    input  logic [4:0]      ex_rs1,
    input  logic [4:0]      ex_rs2,
    input  logic [xlen-1:0] ex_rs1_data,
    input  logic [xlen-1:0] ex_rs2_data,
    input  logic [xlen-1:0] ex_imm,
    input  logic            ex_use_imm,
    input  logic [4:0]      ex_rd,
    input  logic            ex_wen,
    input  logic            ex_halt,
    output logic            wb_valid,
    output logic [xlen-1:0] wb_pc,
    output logic [4:0]      wb_rd,
    output logic            wb_wen,
    output logic [xlen-1:0] wb_data,
    output logic            wb_halt
);

    logic            fwd_a;
    logic            fwd_b;
    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] src_b;
    logic [xlen-1:0] result;

    // Bypass from the instruction one ahead
    assign fwd_a = wb_wen && (wb_rd != 5'd0) && (wb_rd == ex_rs1);
    assign fwd_b = wb_wen && (wb_rd != 5'd0) && (wb_rd == ex_rs2);
    assign op_a  = fwd_a ? wb_data : ex_rs1_data;
    assign op_b  = fwd_b ? wb_data : ex_rs2_data;
    assign src_b = ex_use_imm ? ex_imm : op_b;

    always_comb begin
        case (ex_alu_op)
            alu_add:    result = op_a + src_b;
            alu_sub:    result = op_a - src_b;
            alu_and:    result = op_a & src_b;
            alu_or:     result = op_a | src_b;
            alu_xor:    result = op_a ^ src_b;
            alu_slt:    result = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(src_b)};
            alu_sll:    result = op_a << src_b[4:0];
            alu_srl:    result = op_a >> src_b[4:0];
            alu_pass_b: result = src_b;
            default:    result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wb_valid <= 1'b0;
            wb_wen   <= 1'b0;
            wb_halt  <= 1'b0;
        end else begin
            wb_valid <= ex_valid;
            wb_wen   <= ex_wen;
            wb_halt  <= ex_halt;
        end
    end

    always_ff @(posedge clk) begin
        wb_pc   <= ex_pc;
        wb_rd   <= ex_rd;
        wb_data <= result;
    end

endmodule

// File: hdl/result_unit.sv
`timescale 1ns/1ps

module result_unit import core_pkg::*; (
    input  logic            clk,
    input  logic            rstn,
    input  logic            wb_valid,
    input  logic [xlen-1:0] wb_pc,
    input  logic [4:0]      wb_rd,
    input  logic            wb_wen,
    input  logic [xlen-1:0] wb_data,
    input  logic            wb_halt,
    output logic            rf_wen,
    output logic [4:0]      rf_waddr,
    output logic [xlen-1:0] rf_wdata,
    output logic            commit_valid,
    output logic [xlen-1:0] commit_pc,
    output logic [4:0]      commit_rd,
    output logic [xlen-1:0] commit_data,
    output logic            commit_wen,
    output logic            halted
);

    logic halted_q;

    // Write back
    assign rf_wen   = wb_valid && wb_wen;
    assign rf_waddr = wb_rd;
    assign rf_wdata = wb_data;

    // Retirement report
    assign commit_valid = wb_valid;
    assign commit_pc    = wb_pc;
    assign commit_rd    = wb_rd;
    assign commit_data  = wb_data;
    assign commit_wen   = wb_valid && wb_wen;

    // Rises with the halting commit itself
    assign halted = halted_q || (wb_valid && wb_halt);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            halted_q <= 1'b0;
        end else if (wb_valid && wb_halt) begin
            halted_q <= 1'b1;
        end
    end

endmodule

// File: hdl/core_top.sv
`timescale 1ns/1ps

module core_top import core_pkg::*; (
    input  logic            clk,
    input  logic            rstn,
    output logic [xlen-1:0] fetch_addr,
    input  logic [xlen-1:0] fetch_data,
    output logic            commit_valid,
    output logic [xlen-1:0] commit_pc,
    output logic [4:0]      commit_rd,
    output logic [xlen-1:0] commit_data,
    output logic            commit_wen,
    output logic            halted
);

    // Fetch to decode
    logic            stop;
    logic            id_valid;
    logic [xlen-1:0] id_pc;
    logic [xlen-1:0] id_instr;

    // Register file ports
    logic [4:0]      rs1_addr;
    logic [4:0]      rs2_addr;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic            rf_wen;
    logic [4:0]      rf_waddr;
    logic [xlen-1:0] rf_wdata;

    // Decode to execute
    logic            ex_valid;
    logic [xlen-1:0] ex_pc;
    alu_op_e         ex_alu_op;
    logic [4:0]      ex_rs1;
    logic [4:0]      ex_rs2;
    logic [xlen-1:0] ex_rs1_data;
    logic [xlen-1:0] ex_rs2_data;
    logic [xlen-1:0] ex_imm;
    logic            ex_use_imm;
    logic [4:0]      ex_rd;
    logic            ex_wen;
    logic            ex_halt;

    // Execute to result
    logic            wb_valid;
    logic [xlen-1:0] wb_pc;
    logic [4:0]      wb_rd;
    logic            wb_wen;
    logic [xlen-1:0] wb_data;
    logic            wb_halt;

////////////////////////////////////////
// Fetch and decode

    fetch_unit fetch0 (
        .clk        (clk),
        .rstn       (rstn),
        .fetch_data (fetch_data),
        .stop       (stop),
        .fetch_addr (fetch_addr),
        .id_valid   (id_valid),
        .id_pc      (id_pc),
        .id_instr   (id_instr)
    );

    decode_unit decode0 (
        .clk         (clk),
        .rstn        (rstn),
        .id_valid    (id_valid),
        .id_pc       (id_pc),
        .id_instr    (id_instr),
        .stop        (stop),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .ex_valid    (ex_valid),
        .ex_pc       (ex_pc),
        .ex_alu_op   (ex_alu_op),
        .ex_rs1      (ex_rs1),
        .ex_rs2      (ex_rs2),
        .ex_rs1_data (ex_rs1_data),
        .ex_rs2_data (ex_rs2_data),
        .ex_imm      (ex_imm),
        .ex_use_imm  (ex_use_imm),
        .ex_rd       (ex_rd),
        .ex_wen      (ex_wen),
        .ex_halt     (ex_halt)
    );

    reg_file regs0 (
        .clk      (clk),
        .rstn     (rstn),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .rf_wen   (rf_wen),
        .rf_waddr (rf_waddr),
        .rf_wdata (rf_wdata)
    );

////////////////////////////////////////
// Execute and result

    execute_unit execute0 (
        .clk         (clk),
        .rstn        (rstn),
        .ex_valid    (ex_valid),
        .ex_pc       (ex_pc),
        .ex_alu_op   (ex_alu_op),
        .ex_rs1      (ex_rs1),
        .ex_rs2      (ex_rs2),
        .ex_rs1_data (ex_rs1_data),
        .ex_rs2_data (ex_rs2_data),
        .ex_imm      (ex_imm),
        .ex_use_imm  (ex_use_imm),
        .ex_rd       (ex_rd),
        .ex_wen      (ex_wen),
        .ex_halt     (ex_halt),
        .wb_valid    (wb_valid),
        .wb_pc       (wb_pc),
        .wb_rd       (wb_rd),
        .wb_wen      (wb_wen),
        .wb_data     (wb_data),
        .wb_halt     (wb_halt)
    );

    result_unit result0 (
        .clk          (clk),
        .rstn         (rstn),
        .wb_valid     (wb_valid),
        .wb_pc        (wb_pc),
        .wb_rd        (wb_rd),
        .wb_wen       (wb_wen),
        .wb_data      (wb_data),
        .wb_halt      (wb_halt),
        .rf_wen       (rf_wen),
        .rf_waddr     (rf_waddr),
        .rf_wdata     (rf_wdata),
        .commit_valid (commit_valid),
        .commit_pc    (commit_pc),
        .commit_rd    (commit_rd),
        .commit_data  (commit_data),
        .commit_wen   (commit_wen),
        .halted       (halted)
    );

endmodule

// File: bench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

endmodule

// File: bench/tb_core.sv
`timescale 1ns/1ps

module tb_core import core_pkg::*; ();

    logic            clk;
    logic            rstn;
    logic [xlen-1:0] fetch_addr;
    logic [xlen-1:0] fetch_data;
    logic            commit_valid;
    logic [xlen-1:0] commit_pc;
    logic [4:0]      commit_rd;
    logic [xlen-1:0] commit_data;
    logic            commit_wen;
    logic            halted;

    // Instruction memory, 256 words from address 0
    logic [31:0] imem [0:255];
    logic [31:0] prog_q [$];
    logic [31:0] model_regs [0:31];

    integer seed;
    int     errors;
    int     tests_ok;
    int     tests_bad;
    int     first_commit;
    int     commits;

    tb_clock clock0 (.clk(clk));

    core_top dut0 (
        .clk          (clk),
        .rstn         (rstn),
        .fetch_addr   (fetch_addr),
        .fetch_data   (fetch_data),
        .commit_valid (commit_valid),
        .commit_pc    (commit_pc),
        .commit_rd    (commit_rd),
        .commit_data  (commit_data),
        .commit_wen   (commit_wen),
        .halted       (halted)
    );

    // Zero outside the array, which the core treats as a halt
    assign fetch_data = (fetch_addr < 32'd1024) ? imem[fetch_addr[9:2]] : 32'h0;

////////////////////////////////////////
// Instruction encoding

    function automatic logic [31:0] r_word(input logic [2:0] f3, input logic [6:0] f7,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, opc_op};
    endfunction

    function automatic logic [31:0] i_word(input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc_op_imm};
    endfunction

    function automatic logic [31:0] lui_word(input logic [4:0] rd, input logic [19:0] upper);
        return {upper, rd, opc_lui};
    endfunction

    function automatic logic [31:0] ecall_word();
        return {25'd0, opc_system};
    endfunction

    function automatic logic [31:0] random_alu(input int sel, input logic [4:0] rd,
                                               input logic [4:0] rs1, input logic [4:0] rs2,
                                               input logic [11:0] imm,
                                               input logic [19:0] upper);
        case (sel)
            0:       return r_word(f3_add, 7'd0, rd, rs1, rs2);
            1:       return r_word(f3_add, f7_alt, rd, rs1, rs2);
            2:       return r_word(f3_and, 7'd0, rd, rs1, rs2);
            3:       return r_word(f3_or, 7'd0, rd, rs1, rs2);
            4:       return r_word(f3_xor, 7'd0, rd, rs1, rs2);
            5:       return r_word(f3_slt, 7'd0, rd, rs1, rs2);
            6:       return r_word(f3_sll, 7'd0, rd, rs1, rs2);
            7:       return r_word(f3_srl, 7'd0, rd, rs1, rs2);
            8:       return i_word(f3_add, rd, rs1, imm);
            9:       return i_word(f3_and, rd, rs1, imm);
            10:      return i_word(f3_or, rd, rs1, imm);
            11:      return i_word(f3_xor, rd, rs1, imm);
            12:      return i_word(f3_slt, rd, rs1, imm);
            default: return lui_word(rd, upper);
        endcase
    endfunction

    task automatic emit(input logic [31:0] w);
        prog_q.push_back(w);
    endtask

////////////////////////////////////////
// Reference model and checks

    task automatic expect_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("FAIL %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // One instruction in program order, ISA rules only
    task automatic model_step(input logic [31:0] w, output logic wen, output logic [4:0] rd,
                              output logic [31:0] data, output logic halt);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic        legal;

        opc   = w[6:0];
        rd    = w[11:7];
        f3    = w[14:12];
        f7    = w[31:25];
        a     = model_regs[w[19:15]];
        b     = model_regs[w[24:20]];
        imm   = {{20{w[31]}}, w[31:20]};
        data  = 32'h0;
        legal = 1'b0;
        halt  = (w == 32'h0) || (opc == opc_system);
        if (opc == opc_op && (f7 == 7'd0 || (f7 == f7_alt && f3 == f3_add))) begin
            legal = 1'b1;
            case (f3)
                f3_add:  data = (f7 == f7_alt) ? a - b : a + b;
                f3_sll:  data = a << b[4:0];
                f3_slt:  data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                f3_xor:  data = a ^ b;
                f3_srl:  data = a >> b[4:0];
                f3_or:   data = a | b;
                f3_and:  data = a & b;
                default: legal = 1'b0;
            endcase
        end else if (opc == opc_op_imm) begin
            legal = 1'b1;
            case (f3)
                f3_add:  data = a + imm;
                f3_slt:  data = ($signed(a) < $signed(imm)) ? 32'd1 : 32'd0;
                f3_xor:  data = a ^ imm;
                f3_or:   data = a | imm;
                f3_and:  data = a & imm;
                default: legal = 1'b0;
            endcase
        end else if (opc == opc_lui) begin
            legal = 1'b1;
            data  = {w[31:12], 12'h000};
        end
        wen = legal && (rd != 5'd0);
        if (wen) begin
            model_regs[rd] = data;
        end
    endtask

    task automatic check_commit(input int idx);
        logic [31:0] w;
        logic        wen;
        logic [4:0]  rd;
        logic [31:0] data;
        logic        halt;

        w = (idx < prog_q.size()) ? prog_q[idx] : 32'h0;
        model_step(w, wen, rd, data, halt);
        expect_eq(commit_pc, 32'(idx * 4), $sformatf("commit_pc of commit %0d", idx));
        expect_eq(32'(commit_rd), 32'(rd), $sformatf("commit_rd at pc %h", idx * 4));
        expect_eq(32'(commit_wen), 32'(wen), $sformatf("commit_wen at pc %h", idx * 4));
        if (wen) begin
            expect_eq(commit_data, data, $sformatf("commit_data at pc %h", idx * 4));
        end
        expect_eq(32'(halted), 32'(halt), $sformatf("halted at pc %h", idx * 4));
    endtask

    // Load, reset, then follow commits until the halt
    task automatic run_program();
        int          cyc;
        int          idx;
        logic        done;
        logic [31:0] held_addr;

        @(posedge clk);
        rstn <= 1'b0;
        for (int i = 0; i < 256; i++) begin
            imem[i] <= (i < prog_q.size()) ? prog_q[i] : 32'h0;
        end
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = 32'h0;
        end
        repeat (5) @(posedge clk);
        rstn <= 1'b1;

        cyc          = 0;
        idx          = 0;
        done         = 1'b0;
        first_commit = -1;
        while (!done && cyc < 200) begin
            @(negedge clk);
            if (cyc == 0) begin
                expect_eq(fetch_addr, 32'h0, "fetch_addr in first cycle");
            end
            if (commit_valid) begin
                if (first_commit < 0) begin
                    first_commit = cyc;
                end
                check_commit(idx);
                idx++;
                done = halted;
            end else begin
                expect_eq(32'(halted), 32'h0, "halted without a commit");
            end
            cyc++;
        end
        commits = idx;

        if (!done) begin
            $display("ERROR at %0t ns: core never halted within 200 cycles", $time);
            errors++;
        end else begin
            expect_eq(32'(first_commit), 32'd3, "cycles from fetch_addr 0 to first commit");
            held_addr = fetch_addr;
            for (int k = 0; k < 10; k++) begin
                @(negedge clk);
                expect_eq(32'(commit_valid), 32'h0, "commit_valid after halt");
                expect_eq(fetch_addr, held_addr, "fetch_addr after halt");
                expect_eq(32'(halted), 32'h1, "halted level");
            end
        end
    endtask

    task automatic report_test(input string name, input int start);
        if (errors == start) begin
            tests_ok++;
            $display("%-18s ok", name);
        end else begin
            tests_bad++;
            $display("%-18s %0d errors", name, errors - start);
        end
    endtask

////////////////////////////////////////
// Directed tests

    task automatic rtype_ops();
        int start;
        start = errors;
        prog_q.delete();
        emit(i_word(f3_add, 5'd1, 5'd0, 12'hff9));
        emit(i_word(f3_add, 5'd2, 5'd0, 12'd3));
        emit(lui_word(5'd3, 20'h80001));
        emit(i_word(f3_add, 5'd4, 5'd0, 12'd12));
        emit(r_word(f3_add, 7'd0, 5'd5, 5'd1, 5'd2));
        emit(r_word(f3_add, f7_alt, 5'd6, 5'd1, 5'd2));
        emit(r_word(f3_and, 7'd0, 5'd7, 5'd1, 5'd3));
        emit(r_word(f3_or, 7'd0, 5'd8, 5'd1, 5'd2));
        emit(r_word(f3_xor, 7'd0, 5'd9, 5'd1, 5'd3));
        // Signed compares with negative operands
        emit(r_word(f3_slt, 7'd0, 5'd10, 5'd1, 5'd2));
        emit(r_word(f3_slt, 7'd0, 5'd11, 5'd2, 5'd1));
        emit(r_word(f3_slt, 7'd0, 5'd12, 5'd3, 5'd1));
        emit(r_word(f3_sll, 7'd0, 5'd13, 5'd2, 5'd4));
        emit(r_word(f3_srl, 7'd0, 5'd14, 5'd3, 5'd4));
        emit(r_word(f3_sll, 7'd0, 5'd15, 5'd3, 5'd1));
        emit(ecall_word());
        run_program();
        report_test("rtype_ops", start);
    endtask

    task automatic itype_ops();
        int start;
        start = errors;
        prog_q.delete();
        emit(i_word(f3_add, 5'd1, 5'd0, 12'h800));
        emit(i_word(f3_add, 5'd2, 5'd1, 12'h7ff));
        emit(i_word(f3_and, 5'd3, 5'd2, 12'hf0f));
        emit(i_word(f3_or, 5'd4, 5'd0, 12'hfff));
        emit(i_word(f3_xor, 5'd5, 5'd4, 12'h555));
        emit(i_word(f3_slt, 5'd6, 5'd1, 12'hfff));
        emit(i_word(f3_slt, 5'd7, 5'd4, 12'h000));
        emit(i_word(f3_slt, 5'd8, 5'd2, 12'hffb));
        emit(i_word(f3_add, 5'd9, 5'd0, 12'h123));
        emit(lui_word(5'd10, 20'hfffff));
        emit(lui_word(5'd11, 20'h12345));
        emit(i_word(f3_add, 5'd11, 5'd11, 12'h678));
        emit(ecall_word());
        run_program();
        report_test("itype_ops", start);
    endtask

    // Distance one goes through the bypass, distance two through the register file
    task automatic dependency_chain();
        int start;
        start = errors;
        prog_q.delete();
        emit(i_word(f3_add, 5'd1, 5'd0, 12'd5));
        emit(i_word(f3_add, 5'd2, 5'd1, 12'd1));
        emit(r_word(f3_add, 7'd0, 5'd3, 5'd2, 5'd1));
        emit(r_word(f3_add, f7_alt, 5'd4, 5'd3, 5'd2));
        emit(r_word(f3_xor, 7'd0, 5'd5, 5'd4, 5'd3));
        emit(r_word(f3_sll, 7'd0, 5'd6, 5'd5, 5'd4));
        emit(r_word(f3_or, 7'd0, 5'd7, 5'd6, 5'd6));
        emit(r_word(f3_add, 7'd0, 5'd7, 5'd7, 5'd7));
        emit(i_word(f3_add, 5'd7, 5'd7, 12'd1));
        emit(r_word(f3_slt, 7'd0, 5'd8, 5'd7, 5'd6));
        emit(ecall_word());
        run_program();
        report_test("dependency_chain", start);
    endtask

    task automatic zero_reg_unknown();
        int start;
        start = errors;
        prog_q.delete();
        emit(r_word(f3_add, 7'd0, 5'd5, 5'd6, 5'd7));
        emit(i_word(f3_add, 5'd0, 5'd0, 12'd123));
        emit(i_word(f3_add, 5'd1, 5'd0, 12'd9));
        emit(r_word(f3_add, 7'd0, 5'd0, 5'd1, 5'd1));
        emit(r_word(f3_add, 7'd0, 5'd2, 5'd0, 5'd1));
        // Opcode 7'h7f with rd x1
        emit(32'h0000_00ff);
        emit(r_word(f3_add, 7'd1, 5'd1, 5'd1, 5'd1));
        emit(i_word(f3_sll, 5'd1, 5'd1, 12'd1));
        emit(r_word(f3_or, 7'd0, 5'd3, 5'd1, 5'd0));
        emit(r_word(f3_add, 7'd0, 5'd4, 5'd0, 5'd0));
        emit(ecall_word());
        run_program();
        report_test("zero_reg_unknown", start);
    endtask

    task automatic halt_sequence();
        int start;
        start = errors;
        prog_q.delete();
        emit(i_word(f3_add, 5'd1, 5'd0, 12'd1));
        emit(i_word(f3_add, 5'd2, 5'd1, 12'd2));
        emit(ecall_word());
        emit(i_word(f3_add, 5'd3, 5'd0, 12'd7));
        emit(i_word(f3_add, 5'd4, 5'd0, 12'd8));
        run_program();
        expect_eq(32'(commits), 32'd3, "commits up to ECALL");
        // All-zero word right after the program
        prog_q.delete();
        emit(i_word(f3_add, 5'd1, 5'd0, 12'd4));
        emit(i_word(f3_add, 5'd2, 5'd1, 12'd4));
        run_program();
        expect_eq(32'(commits), 32'd3, "commits up to zero word");
        report_test("halt_sequence", start);
    endtask

    task automatic random_program();
        int          start;
        int          sel;
        logic [31:0] rnd;
        logic [31:0] pick;

        start = errors;
        seed  = 78;
        prog_q.delete();
        for (int n = 0; n < 40; n++) begin
            rnd  = $random(seed);
            pick = $random(seed);
            sel  = int'(pick[7:0]) % 14;
            emit(random_alu(sel, {2'b00, rnd[2:0]}, {2'b00, rnd[5:3]}, {2'b00, rnd[8:6]},
                            rnd[20:9], rnd[31:12]));
        end
        emit(ecall_word());
        run_program();
        report_test("random_program", start);
    endtask

    initial begin
        rstn      = 1'b0;
        errors    = 0;
        tests_ok  = 0;
        tests_bad = 0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = 32'h0;
        end

        rtype_ops();
        itype_ops();
        dependency_chain();
        zero_reg_unknown();
        halt_sequence();
        random_program();

        $display("Summary: %0d tests ok, %0d tests with errors, %0d errors in total",
                 tests_ok, tests_bad, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: flist.f
hdl/core_pkg.sv
hdl/fetch_unit.sv
hdl/reg_file.sv
hdl/decode_unit.sv
hdl/execute_unit.sv
hdl/result_unit.sv
hdl/core_top.sv
bench/tb_clock.sv
bench/tb_core.sv

// File: Bender.yml
package:
  name: rv32i_core

sources:
  - files:
      - hdl/core_pkg.sv
      - hdl/fetch_unit.sv
      - hdl/reg_file.sv
      - hdl/decode_unit.sv
      - hdl/execute_unit.sv
      - hdl/result_unit.sv
      - hdl/core_top.sv
  - target: simulation
    files:
      - bench/tb_clock.sv
      - bench/tb_core.sv
